// File: logic/seq_settings.svh
////////////////////////////////////////////////////////////
// Vector sequencer sizing
////////////////////////////////////////////////////////////

`ifndef SEQ_SETTINGS_SVH
`define SEQ_SETTINGS_SVH

// Instruction IDs in flight at once
`define SEQ_NR_VINSN 4

// Architectural vector registers
// v0 doubles as the mask register
`define SEQ_NR_VREGS 32

// Functional units behind the sequencer
`define SEQ_NR_UNITS 5

// Instructions each unit queue can hold
`define SEQ_QUEUE_DEPTH 2

`endif

// File: logic/vinsn_pkg.sv
////////////////////////////////////////////////////////////
// Vector instruction types
////////////////////////////////////////////////////////////

`default_nettype none

`include "seq_settings.svh"

package vinsn_pkg;

  // Supported vector operations
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VMUL,
    VFADD,
    VMSEQ,
    VMAND,
    VLE,
    VSE
  } op_e;

  // Functional units, values are also bit positions in unit_mask_t
  typedef enum logic [2:0] {
    UNIT_ALU   = 3'd0,
    UNIT_MFPU  = 3'd1,
    UNIT_MASKU = 3'd2,
    UNIT_LOAD  = 3'd3,
    UNIT_STORE = 3'd4
  } unit_e;

  // Vector register index
  typedef logic [$clog2(`SEQ_NR_VREGS)-1:0] vreg_t;

  // One bit per functional unit
  typedef logic [`SEQ_NR_UNITS-1:0] unit_mask_t;

endpackage

`default_nettype wire

// File: logic/seq_pkg.sv
////////////////////////////////////////////////////////////
// Sequencer bookkeeping types
////////////////////////////////////////////////////////////

`default_nettype none

`include "seq_settings.svh"

package seq_pkg;

  // Instruction ID handed out on acceptance
  typedef logic [$clog2(`SEQ_NR_VINSN)-1:0] vid_t;

  // One bit per instruction ID
  // Used for running vectors, hazard vectors and table rows
  typedef logic [`SEQ_NR_VINSN-1:0] vinsn_mask_t;

  // Queue occupancy of one unit
  // Counts from zero up to and including the queue depth
  typedef logic [$clog2(`SEQ_QUEUE_DEPTH+1)-1:0] queue_cnt_t;

endpackage

`default_nettype wire

// File: logic/seq_decode.sv
////////////////////////////////////////////////////////////
// Opcode to unit decode
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module seq_decode (
  input  vinsn_pkg::op_e       op_i,
  input  logic                 vm_i,
  output vinsn_pkg::unit_e     primary_unit_o,
  output vinsn_pkg::unit_mask_t target_units_o
);

  import vinsn_pkg::*;

  always_comb begin : p_decode
    primary_unit_o = UNIT_ALU;
    target_units_o = '0;
    case (op_i)
      // Integer arithmetic
      VADD, VSUB: begin
        primary_unit_o = UNIT_ALU;
        target_units_o[UNIT_ALU] = 1'b1;
      end
      // Multiply and floating point
      VMUL, VFADD: begin
        primary_unit_o = UNIT_MFPU;
        target_units_o[UNIT_MFPU] = 1'b1;
      end
      // Compare runs on the ALU
      // The mask unit packs the result bits
      VMSEQ: begin
        primary_unit_o = UNIT_MASKU;
        target_units_o[UNIT_ALU]   = 1'b1;
        target_units_o[UNIT_MASKU] = 1'b1;
      end
      VMAND: begin
        primary_unit_o = UNIT_MASKU;
        target_units_o[UNIT_MASKU] = 1'b1;
      end
      VLE: begin
        primary_unit_o = UNIT_LOAD;
        target_units_o[UNIT_LOAD] = 1'b1;
      end
      VSE: begin
        primary_unit_o = UNIT_STORE;
        target_units_o[UNIT_STORE] = 1'b1;
      end
    endcase
    // Masked instructions also need the mask unit
    if (!vm_i) begin
      target_units_o[UNIT_MASKU] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/seq_scoreboard.sv
////////////////////////////////////////////////////////////
// Register access lists and hazards
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "seq_settings.svh"

module seq_scoreboard (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vinsn_pkg::vreg_t     vd_i,
  input  vinsn_pkg::vreg_t     vs1_i,
  input  vinsn_pkg::vreg_t     vs2_i,
  input  logic                 use_vd_i,
  input  logic                 use_vs1_i,
  input  logic                 use_vs2_i,
  input  logic                 vm_i,
  input  logic                 accept_i,
  input  seq_pkg::vid_t        new_id_i,
  input  seq_pkg::vinsn_mask_t running_i,
  output seq_pkg::vinsn_mask_t hazard_o
);

  import seq_pkg::*;

  // Last reader and last writer of each register
  logic [`SEQ_NR_VREGS-1:0] rd_valid_q, rd_valid_d;
  logic [`SEQ_NR_VREGS-1:0] wr_valid_q, wr_valid_d;
  vid_t rd_vid_q [`SEQ_NR_VREGS];
  vid_t rd_vid_d [`SEQ_NR_VREGS];
  vid_t wr_vid_q [`SEQ_NR_VREGS];
  vid_t wr_vid_d [`SEQ_NR_VREGS];

  // Entries whose instruction still runs
  logic [`SEQ_NR_VREGS-1:0] rd_live, wr_live;

  // One-hot ID bit, zero when the entry is stale
  function automatic vinsn_mask_t id_bit(vid_t id, logic live);
    vinsn_mask_t m;
    m     = '0;
    m[id] = live;
    return m;
  endfunction

  always_comb begin : p_live
    for (int r = 0; r < `SEQ_NR_VREGS; r++) begin
      rd_live[r] = rd_valid_q[r] & running_i[rd_vid_q[r]];
      wr_live[r] = wr_valid_q[r] & running_i[wr_vid_q[r]];
    end
  end

  ////////////////////////////////////////////////////////////
  // Hazard vector
  ////////////////////////////////////////////////////////////

  always_comb begin : p_hazard
    hazard_o = '0;
    // RAW on sources and on the mask in v0
    if (use_vs1_i) hazard_o |= id_bit(wr_vid_q[vs1_i], wr_live[vs1_i]);
    if (use_vs2_i) hazard_o |= id_bit(wr_vid_q[vs2_i], wr_live[vs2_i]);
    if (!vm_i) hazard_o |= id_bit(wr_vid_q[0], wr_live[0]);
    // WAR and WAW on the destination
    if (use_vd_i) begin
      hazard_o |= id_bit(rd_vid_q[vd_i], rd_live[vd_i]);
      hazard_o |= id_bit(wr_vid_q[vd_i], wr_live[vd_i]);
    end
  end

  ////////////////////////////////////////////////////////////
  // List update
  ////////////////////////////////////////////////////////////

  always_comb begin : p_lists
    // Drop entries of retired IDs so a reused ID starts clean
    rd_valid_d = rd_live;
    wr_valid_d = wr_live;
    rd_vid_d   = rd_vid_q;
    wr_vid_d   = wr_vid_q;
    if (accept_i) begin
      if (use_vd_i) begin
        wr_valid_d[vd_i] = 1'b1;
        wr_vid_d[vd_i]   = new_id_i;
      end
      // Newest reader takes over the entry
      if (use_vs1_i) begin
        rd_valid_d[vs1_i] = 1'b1;
        rd_vid_d[vs1_i]   = new_id_i;
      end
      if (use_vs2_i) begin
        rd_valid_d[vs2_i] = 1'b1;
        rd_vid_d[vs2_i]   = new_id_i;
      end
      if (!vm_i) begin
        rd_valid_d[0] = 1'b1;
        rd_vid_d[0]   = new_id_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid_ff
    if (!rst_ni) begin
      rd_valid_q <= '0;
      wr_valid_q <= '0;
    end else begin
      rd_valid_q <= rd_valid_d;
      wr_valid_q <= wr_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_vid_ff
    rd_vid_q <= rd_vid_d;
    wr_vid_q <= wr_vid_d;
  end

endmodule

`default_nettype wire

// File: logic/seq_issue.sv
////////////////////////////////////////////////////////////
// Acceptance, ID allocation and issue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "seq_settings.svh"

module seq_issue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  vinsn_pkg::op_e        op_i,
  input  vinsn_pkg::unit_e      primary_unit_i,
  input  vinsn_pkg::unit_mask_t target_units_i,
  input  seq_pkg::vinsn_mask_t  hazard_i,
  input  seq_pkg::vinsn_mask_t  running_i,
  input  seq_pkg::vinsn_mask_t  next_running_i,
  input  vinsn_pkg::unit_mask_t unit_busy_done_i,
  output logic                  accept_o,
  output seq_pkg::vid_t         new_id_o,
  output logic                  pe_valid_o,
  output seq_pkg::vid_t         pe_id_o,
  output vinsn_pkg::unit_e      pe_unit_o,
  output vinsn_pkg::op_e        pe_op_o,
  output seq_pkg::vinsn_mask_t  pe_hazard_o,
  output seq_pkg::vinsn_mask_t  global_hazard_table_o [`SEQ_NR_VINSN]
);

  import seq_pkg::*;

  logic                     id_free;
  // High when a unit is not targeted or still has room
  logic [`SEQ_NR_UNITS-1:0] unit_ok;
  vinsn_mask_t              table_d [`SEQ_NR_VINSN];

  // Lowest ID that is not running
  always_comb begin : p_alloc
    new_id_o = '0;
    id_free  = 1'b0;
    for (int i = `SEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_i[i]) begin
        new_id_o = vid_t'(i);
        id_free  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Unit queue counters
  ////////////////////////////////////////////////////////////

  for (genvar u = 0; u < `SEQ_NR_UNITS; u++) begin : gen_queue_cnt
    queue_cnt_t cnt_q;
    logic       cnt_up;
    logic       cnt_down;

    assign cnt_up   = accept_o & target_units_i[u];
    // Never wrap below zero on a stray done
    assign cnt_down = unit_busy_done_i[u] & (cnt_q != '0);
    assign unit_ok[u] = ~target_units_i[u] | (cnt_q < queue_cnt_t'(`SEQ_QUEUE_DEPTH));

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt_ff
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Free ID and room in every target queue
  assign req_ready_o = id_free & (&unit_ok);
  assign accept_o    = req_valid_i & req_ready_o;

  ////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid_ff
    if (!rst_ni) begin
      pe_valid_o <= 1'b0;
    end else begin
      pe_valid_o <= accept_o;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload_ff
    if (accept_o) begin
      pe_id_o     <= new_id_o;
      pe_unit_o   <= primary_unit_i;
      pe_op_o     <= op_i;
      pe_hazard_o <= hazard_i;
    end
  end

  // Row N lists the IDs that instruction N waits on
  always_comb begin : p_table
    for (int i = 0; i < `SEQ_NR_VINSN; i++) begin
      table_d[i] = global_hazard_table_o[i];
      if (accept_o && (new_id_o == vid_t'(i))) begin
        table_d[i] = hazard_i;
      end
      // Columns of finished IDs drop out
      // Rows of finished IDs are emptied
      table_d[i] = next_running_i[i] ? (table_d[i] & next_running_i) : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_table_ff
    if (!rst_ni) begin
      global_hazard_table_o <= '{default: '0};
    end else begin
      global_hazard_table_o <= table_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/seq_completion.sv
////////////////////////////////////////////////////////////
// Running matrix and completion
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "seq_settings.svh"

module seq_completion (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  accept_i,
  input  seq_pkg::vid_t         new_id_i,
  input  vinsn_pkg::unit_e      primary_unit_i,
  input  logic                  vm_i,
  input  seq_pkg::vinsn_mask_t  unit_done_i [`SEQ_NR_UNITS],
  output seq_pkg::vinsn_mask_t  running_o,
  output seq_pkg::vinsn_mask_t  next_running_o,
  output vinsn_pkg::unit_mask_t unit_busy_done_o,
  output logic                  idle_o
);

  import vinsn_pkg::*;
  import seq_pkg::*;

  // Bit [u][id] set while instruction id runs on unit u
  vinsn_mask_t run_q [`SEQ_NR_UNITS];
  vinsn_mask_t run_d [`SEQ_NR_UNITS];

  always_comb begin : p_running
    // Done pulses only clear bits that are set
    for (int u = 0; u < `SEQ_NR_UNITS; u++) begin
      run_d[u] = run_q[u] & ~unit_done_i[u];
    end
    if (accept_i) begin
      run_d[primary_unit_i][new_id_i] = 1'b1;
      // Masked work also runs on the mask unit
      if (!vm_i) run_d[UNIT_MASKU][new_id_i] = 1'b1;
    end
  end

  // Collapse the matrix over units
  always_comb begin : p_reduce
    running_o      = '0;
    next_running_o = '0;
    for (int u = 0; u < `SEQ_NR_UNITS; u++) begin
      running_o           |= run_q[u];
      next_running_o      |= run_d[u];
      unit_busy_done_o[u]  = |unit_done_i[u];
    end
  end

  assign idle_o = ~|running_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_running_ff
    if (!rst_ni) begin
      run_q <= '{default: '0};
    end else begin
      run_q <= run_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/vec_sequencer.sv
////////////////////////////////////////////////////////////
// Vector instruction sequencer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "seq_settings.svh"

module vec_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request side
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  vinsn_pkg::op_e       req_op_i,
  input  vinsn_pkg::vreg_t     req_vd_i,
  input  vinsn_pkg::vreg_t     req_vs1_i,
  input  vinsn_pkg::vreg_t     req_vs2_i,
  input  logic                 req_use_vd_i,
  input  logic                 req_use_vs1_i,
  input  logic                 req_use_vs2_i,
  input  logic                 req_vm_i,
  // Completion pulses per unit
  input  seq_pkg::vinsn_mask_t unit_done_i [`SEQ_NR_UNITS],
  // Issue side
  output logic                 pe_valid_o,
  output seq_pkg::vid_t        pe_id_o,
  output vinsn_pkg::unit_e     pe_unit_o,
  output vinsn_pkg::op_e       pe_op_o,
  output seq_pkg::vinsn_mask_t pe_hazard_o,
  // Status
  output seq_pkg::vinsn_mask_t vinsn_running_o,
  output logic                 idle_o,
  output seq_pkg::vinsn_mask_t global_hazard_table_o [`SEQ_NR_VINSN]
);

  import vinsn_pkg::*;
  import seq_pkg::*;

  unit_e       primary_unit;
  unit_mask_t  target_units;
  unit_mask_t  unit_busy_done;
  vinsn_mask_t hazard;
  vinsn_mask_t next_running;
  vid_t        new_id;
  logic        accept;

  seq_decode i_decode (
    .op_i          (req_op_i),
    .vm_i          (req_vm_i),
    .primary_unit_o(primary_unit),
    .target_units_o(target_units)
  );

  seq_scoreboard i_scoreboard (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .vd_i     (req_vd_i),
    .vs1_i    (req_vs1_i),
    .vs2_i    (req_vs2_i),
    .use_vd_i (req_use_vd_i),
    .use_vs1_i(req_use_vs1_i),
    .use_vs2_i(req_use_vs2_i),
    .vm_i     (req_vm_i),
    .accept_i (accept),
    .new_id_i (new_id),
    .running_i(vinsn_running_o),
    .hazard_o (hazard)
  );

  seq_issue i_issue (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .req_valid_i          (req_valid_i),
    .req_ready_o          (req_ready_o),
    .op_i                 (req_op_i),
    .primary_unit_i       (primary_unit),
    .target_units_i       (target_units),
    .hazard_i             (hazard),
    .running_i            (vinsn_running_o),
    .next_running_i       (next_running),
    .unit_busy_done_i     (unit_busy_done),
    .accept_o             (accept),
    .new_id_o             (new_id),
    .pe_valid_o           (pe_valid_o),
    .pe_id_o              (pe_id_o),
    .pe_unit_o            (pe_unit_o),
    .pe_op_o              (pe_op_o),
    .pe_hazard_o          (pe_hazard_o),
    .global_hazard_table_o(global_hazard_table_o)
  );

  seq_completion i_completion (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .accept_i        (accept),
    .new_id_i        (new_id),
    .primary_unit_i  (primary_unit),
    .vm_i            (req_vm_i),
    .unit_done_i     (unit_done_i),
    .running_o       (vinsn_running_o),
    .next_running_o  (next_running),
    .unit_busy_done_o(unit_busy_done),
    .idle_o          (idle_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_vec_sequencer.sv
////////////////////////////////////////////////////////////
// Vector sequencer testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "seq_settings.svh"

module tb_vec_sequencer;

  import vinsn_pkg::*;
  import seq_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_TESTS   = 5;
  // Cycle budget of one directed test including reset
  localparam int TEST_CYCLES = 200;
  localparam int STALL_LIMIT = 50;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  op_e         req_op;
  vreg_t       req_vd;
  vreg_t       req_vs1;
  vreg_t       req_vs2;
  logic        req_use_vd;
  logic        req_use_vs1;
  logic        req_use_vs2;
  logic        req_vm;
  vinsn_mask_t unit_done [`SEQ_NR_UNITS];
  logic        pe_valid;
  vid_t        pe_id;
  unit_e       pe_unit;
  op_e         pe_op;
  vinsn_mask_t pe_hazard;
  vinsn_mask_t running;
  logic        idle;
  vinsn_mask_t hz_table [`SEQ_NR_VINSN];

  // Expected running bits as one mask per unit
  vinsn_mask_t exp_run [`SEQ_NR_UNITS];

  vec_sequencer dut_i (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .req_valid_i          (req_valid),
    .req_ready_o          (req_ready),
    .req_op_i             (req_op),
    .req_vd_i             (req_vd),
    .req_vs1_i            (req_vs1),
    .req_vs2_i            (req_vs2),
    .req_use_vd_i         (req_use_vd),
    .req_use_vs1_i        (req_use_vs1),
    .req_use_vs2_i        (req_use_vs2),
    .req_vm_i             (req_vm),
    .unit_done_i          (unit_done),
    .pe_valid_o           (pe_valid),
    .pe_id_o              (pe_id),
    .pe_unit_o            (pe_unit),
    .pe_op_o              (pe_op),
    .pe_hazard_o          (pe_hazard),
    .vinsn_running_o      (running),
    .idle_o               (idle),
    .global_hazard_table_o(hz_table)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // Unit that executes each opcode
  function automatic unit_e unit_of(op_e op);
    case (op)
      VADD, VSUB:   return UNIT_ALU;
      VMUL, VFADD:  return UNIT_MFPU;
      VMSEQ, VMAND: return UNIT_MASKU;
      VLE:          return UNIT_LOAD;
      default:      return UNIT_STORE;
    endcase
  endfunction

  function automatic vinsn_mask_t exp_running();
    vinsn_mask_t m;
    m = '0;
    for (int u = 0; u < `SEQ_NR_UNITS; u++) begin
      m |= exp_run[u];
    end
    return m;
  endfunction

  // First ID counting up from zero that nothing runs under
  function automatic vid_t lowest_free();
    vinsn_mask_t busy;
    busy = exp_running();
    for (int i = 0; i < `SEQ_NR_VINSN; i++) begin
      if (!busy[i]) return vid_t'(i);
    end
    return '0;
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at time %0t: %s got 0x%0h, expected 0x%0h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_status();
    check("vinsn_running_o", 32'(running), 32'(exp_running()));
    check("idle_o", 32'(idle), 32'(exp_running() == '0));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic reset_dut();
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_op    = VADD;
    req_vd    = '0;
    req_vs1   = '0;
    req_vs2   = '0;
    req_vm    = 1'b1;
    {req_use_vd, req_use_vs1, req_use_vs2} = 3'b000;
    for (int u = 0; u < `SEQ_NR_UNITS; u++) begin
      unit_done[u] = '0;
      exp_run[u]   = '0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  // Hold one request until accepted and check the issue pulse
  task automatic issue(op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, logic [2:0] uses,
                       logic vm, vinsn_mask_t exp_hz);
    int   waited;
    vid_t exp_id;
    @(posedge clk);
    #2;
    // No acceptance at this edge means no pulse
    check("pe_valid_o", 32'(pe_valid), 32'd0);
    req_valid = 1'b1;
    req_op    = op;
    req_vd    = vd;
    req_vs1   = vs1;
    req_vs2   = vs2;
    req_vm    = vm;
    {req_use_vd, req_use_vs1, req_use_vs2} = uses;
    waited = 0;
    #1;
    while (!req_ready) begin
      @(posedge clk);
      #3;
      waited++;
      if (waited > STALL_LIMIT) fail_run("Request was never accepted by the sequencer");
    end
    exp_id = lowest_free();
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    check("pe_valid_o", 32'(pe_valid), 32'd1);
    check("pe_id_o", 32'(pe_id), 32'(exp_id));
    check("pe_unit_o", 32'(pe_unit), 32'(unit_of(op)));
    check("pe_op_o", 32'(pe_op), 32'(op));
    check("pe_hazard_o", 32'(pe_hazard), 32'(exp_hz));
    check($sformatf("global_hazard_table_o[%0d]", exp_id), 32'(hz_table[exp_id]),
          32'(exp_hz));
    exp_run[unit_of(op)][exp_id] = 1'b1;
    // Masked work also holds the mask unit
    if (!vm) exp_run[UNIT_MASKU][exp_id] = 1'b1;
    check_status();
  endtask

  task automatic done_pulse(unit_e unit, vinsn_mask_t ids);
    @(posedge clk);
    #2;
    unit_done[unit] = ids;
    @(posedge clk);
    #2;
    unit_done[unit] = '0;
    exp_run[unit] &= ~ids;
    check_status();
  endtask

  // Request stalls on a full queue until a done pulse frees a slot
  task automatic stalled_issue(op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, logic [2:0] uses,
                               logic vm, vinsn_mask_t exp_hz, unit_e done_unit,
                               vinsn_mask_t done_ids);
    fork
      issue(op, vd, vs1, vs2, uses, vm, exp_hz);
      begin
        repeat (3) begin
          @(posedge clk);
          #3;
          check("req_ready_o", 32'(req_ready), 32'd0);
        end
        done_pulse(done_unit, done_ids);
      end
    join
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic after_reset_state();
    reset_dut();
    check_status();
    for (int i = 0; i < `SEQ_NR_VINSN; i++) begin
      check($sformatf("global_hazard_table_o[%0d]", i), 32'(hz_table[i]), 32'd0);
    end
    repeat (3) begin
      @(posedge clk);
      #2;
      check("pe_valid_o", 32'(pe_valid), 32'd0);
    end
    check("req_ready_o", 32'(req_ready), 32'd1);
    // Stray done bits with nothing running
    done_pulse(UNIT_ALU, 4'b1111);
    // ALU queue must still read as empty
    check("req_ready_o", 32'(req_ready), 32'd1);
  endtask

  task automatic id_alloc_release();
    reset_dut();
    issue(VADD, 1, 2, 3, 3'b111, 1'b1, 4'b0000);
    issue(VMUL, 4, 5, 6, 3'b111, 1'b1, 4'b0000);
    issue(VADD, 7, 8, 9, 3'b111, 1'b1, 4'b0000);
    issue(VMUL, 10, 11, 12, 3'b111, 1'b1, 4'b0000);
    // Store queue is empty and only the IDs are exhausted
    req_op = VSE;
    #1;
    check("req_ready_o", 32'(req_ready), 32'd0);
    done_pulse(UNIT_MFPU, 4'b0010);
    issue(VSE, 0, 13, 0, 3'b010, 1'b1, 4'b0000);
  endtask

  task automatic dependency_vectors();
    reset_dut();
    issue(VADD, 3, 1, 2, 3'b111, 1'b1, 4'b0000);
    // RAW on v3 against ID 0
    issue(VADD, 4, 3, 5, 3'b111, 1'b1, 4'b0001);
    // WAR against ID 1 and WAW against ID 0
    issue(VMUL, 3, 6, 7, 3'b111, 1'b1, 4'b0011);
    done_pulse(UNIT_ALU, 4'b0001);
    check("global_hazard_table_o[0]", 32'(hz_table[0]), 32'd0);
    check("global_hazard_table_o[1]", 32'(hz_table[1]), 32'd0);
    check("global_hazard_table_o[2]", 32'(hz_table[2]), 32'b0010);
  endtask

  task automatic queue_full_stall();
    reset_dut();
    issue(VADD, 1, 2, 3, 3'b111, 1'b1, 4'b0000);
    issue(VADD, 4, 5, 6, 3'b111, 1'b1, 4'b0000);
    // ALU is full but the multiplier queue is not
    issue(VMUL, 7, 8, 9, 3'b111, 1'b1, 4'b0000);
    stalled_issue(VADD, 10, 11, 12, 3'b111, 1'b1, 4'b0000, UNIT_ALU, 4'b0001);
  endtask

  task automatic masked_mask_unit();
    reset_dut();
    // Producer of the mask in v0
    issue(VMAND, 0, 1, 2, 3'b111, 1'b1, 4'b0000);
    // Masked load reads v0
    issue(VLE, 5, 0, 0, 3'b100, 1'b0, 4'b0001);
    // Both instructions hold a mask unit slot
    stalled_issue(VMAND, 6, 7, 8, 3'b111, 1'b1, 4'b0000, UNIT_MASKU, 4'b0001);
    // Load keeps ID 1 busy after the mask unit lets go
    done_pulse(UNIT_MASKU, 4'b0010);
    done_pulse(UNIT_LOAD, 4'b0010);
    done_pulse(UNIT_MASKU, 4'b0001);
    check("idle_o", 32'(idle), 32'd1);
  endtask

  initial begin : p_main
    clk = 1'b0;
    after_reset_state();
    id_alloc_release();
    dependency_vectors();
    queue_full_stall();
    masked_mask_unit();
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin : p_watchdog
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    fail_run("Watchdog timeout: the tests did not complete in time");
  end

endmodule

`default_nettype wire

// File: vec_sequencer.f
+incdir+logic
logic/vinsn_pkg.sv
logic/seq_pkg.sv
logic/seq_decode.sv
logic/seq_scoreboard.sv
logic/seq_issue.sv
logic/seq_completion.sv
logic/vec_sequencer.sv
tests/tb_vec_sequencer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_vec_sequencer \
  -f vec_sequencer.f -o sim_vec_sequencer || exit 1
out=$(./obj_dir/sim_vec_sequencer 2>&1)
echo "$out"
echo "$out" | grep -qF "Simulation finished: PASS" && exit 0 || exit 1
